// File: common/armCore_macros.svh
`ifndef ARMCORE_MACROS_SVH
`define ARMCORE_MACROS_SVH

// Datapath word width
`define DATA_WIDTH 32

// Architectural register count, r0 to r15
`define REG_COUNT 16

// Register index width
`define REG_ADDR_WIDTH 4

`endif

// File: common/armCorePkg.sv
package armCorePkg;

  // Data-processing encoding
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  zeroes;
    logic        immFlag;
    logic [3:0]  opcode;
    logic        setFlags;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] operand2;
  } dataProcFields;

  // Multiply encoding, marker field is 1001
  typedef struct packed {
    logic [3:0] cond;
    logic [5:0] zeroes;
    logic       accumulate;
    logic       setFlags;
    logic [3:0] rd;
    logic [3:0] rn;
    logic [3:0] rs;
    logic [3:0] marker;
    logic [3:0] rm;
  } multFields;

  typedef union packed {
    dataProcFields dataProc;
    multFields     mult;
  } instrWord;

  typedef enum logic [3:0] {
    opAnd = 4'd0,
    opEor = 4'd1,
    opSub = 4'd2,
    opRsb = 4'd3,
    opAdd = 4'd4,
    opCmp = 4'd10,
    opOrr = 4'd12,
    opMov = 4'd13,
    opMvn = 4'd15
  } aluOp;

  typedef enum logic [1:0] {
    shiftLsl = 2'd0,
    shiftLsr = 2'd1,
    shiftAsr = 2'd2,
    shiftRor = 2'd3
  } shiftType;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagSet;

endpackage

// File: common/decodeBus.sv
`timescale 1ns/100ps
`include "armCore_macros.svh"

interface decodeBus;

  logic                       valid;
  logic                       isMult;
  logic                       accumulate;
  armCorePkg::aluOp           op;
  logic                       setFlags;
  logic [`REG_ADDR_WIDTH-1:0] srcA;
  logic [`REG_ADDR_WIDTH-1:0] srcB;
  logic [`REG_ADDR_WIDTH-1:0] srcS;
  logic                       useImm;
  logic [`DATA_WIDTH-1:0]     immValue;
  logic                       immCarry;
  armCorePkg::shiftType       shiftKind;
  logic [4:0]                 shiftAmount;
  logic [`REG_ADDR_WIDTH-1:0] destReg;
  logic                       writesDest;
  // Handed back by the result stage, empties decode
  logic                       take;

  modport decoder (output valid, isMult, accumulate, op, setFlags, srcA, srcB, srcS,
                   useImm, immValue, immCarry, shiftKind, shiftAmount, destReg, writesDest);

  modport execute (input isMult, accumulate, op, useImm, immValue, immCarry,
                   shiftKind, shiftAmount);

  modport result (input valid, setFlags, destReg, writesDest, output take);

endinterface

// File: decode/instrDecoder.sv
`timescale 1ns/100ps
`include "armCore_macros.svh"

module instrDecoder (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 inReq,
  output logic                 inAck,
  input  armCorePkg::instrWord instruction,
  input  logic                 carryFlag,
  input  logic                 take,
  decodeBus.decoder            bus
);

  armCorePkg::instrWord     instrReg;
  logic                     validReg;
  logic                     capture;
  logic                     isMult;
  armCorePkg::aluOp         decodedOp;
  logic [4:0]               rotAmount;
  logic [`DATA_WIDTH-1:0]   immBase;
  logic [2*`DATA_WIDTH-1:0] rotWide;

  // Slot may refill on the edge the current item leaves
  assign capture = inReq && !inAck && (!validReg || take);

  always_ff @(posedge clk) begin
    if (reset) begin
      inAck    <= 1'b0;
      validReg <= 1'b0;
    end else begin
      if (capture) begin
        inAck <= 1'b1;
      end else if (!inReq) begin
        inAck <= 1'b0;
      end
      if (capture) begin
        validReg <= 1'b1;
      end else if (take) begin
        validReg <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      instrReg <= instruction;
    end
  end

  // Multiply has bits 27:22 clear and 1001 in bits 7:4
  assign isMult = (instrReg.mult.zeroes == '0) && (instrReg.mult.marker == 4'b1001);

  always_comb begin
    case (instrReg.dataProc.opcode)
      4'd0:    decodedOp = armCorePkg::opAnd;
      4'd1:    decodedOp = armCorePkg::opEor;
      4'd2:    decodedOp = armCorePkg::opSub;
      4'd3:    decodedOp = armCorePkg::opRsb;
      4'd4:    decodedOp = armCorePkg::opAdd;
      4'd10:   decodedOp = armCorePkg::opCmp;
      4'd12:   decodedOp = armCorePkg::opOrr;
      4'd15:   decodedOp = armCorePkg::opMvn;
      default: decodedOp = armCorePkg::opMov;
    endcase
  end

  // Rotate right by twice the 4-bit field
  assign rotAmount = {instrReg.dataProc.operand2[11:8], 1'b0};
  assign immBase   = {{(`DATA_WIDTH-8){1'b0}}, instrReg.dataProc.operand2[7:0]};
  assign rotWide   = {immBase, immBase} >> rotAmount;

  assign bus.valid       = validReg;
  assign bus.isMult      = isMult;
  assign bus.accumulate  = isMult && instrReg.mult.accumulate;
  assign bus.op          = decodedOp;
  // The S bit and rm sit at the same bits in both views
  assign bus.setFlags    = instrReg.dataProc.setFlags;
  // Multiply reads rn as accumulator, rm and rs as factors
  assign bus.srcA        = isMult ? instrReg.mult.rn : instrReg.dataProc.rn;
  assign bus.srcB        = instrReg.dataProc.operand2[3:0];
  assign bus.srcS        = instrReg.mult.rs;
  assign bus.useImm      = !isMult && instrReg.dataProc.immFlag;
  assign bus.immValue    = rotWide[`DATA_WIDTH-1:0];
  assign bus.immCarry    = (rotAmount == '0) ? carryFlag : rotWide[`DATA_WIDTH-1];
  assign bus.shiftKind   = armCorePkg::shiftType'(instrReg.dataProc.operand2[6:5]);
  assign bus.shiftAmount = instrReg.dataProc.operand2[11:7];
  assign bus.destReg     = isMult ? instrReg.mult.rd : instrReg.dataProc.rd;
  assign bus.writesDest  = isMult || (decodedOp != armCorePkg::opCmp);

endmodule

// File: source/regFile.sv
`timescale 1ns/100ps
`include "armCore_macros.svh"

module regFile (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`REG_ADDR_WIDTH-1:0] readAddrA,
  input  logic [`REG_ADDR_WIDTH-1:0] readAddrB,
  input  logic [`REG_ADDR_WIDTH-1:0] readAddrS,
  output logic [`DATA_WIDTH-1:0]     readDataA,
  output logic [`DATA_WIDTH-1:0]     readDataB,
  output logic [`DATA_WIDTH-1:0]     readDataS,
  input  logic                       writeEnable,
  input  logic [`REG_ADDR_WIDTH-1:0] writeAddr,
  input  logic [`DATA_WIDTH-1:0]     writeData
);

  logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

  // Architectural state starts from zero
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable) begin
      regs[writeAddr] <= writeData;
    end
  end

  // No bypass, operands are read a cycle after the write
  assign readDataA = regs[readAddrA];
  assign readDataB = regs[readAddrB];
  assign readDataS = regs[readAddrS];

endmodule

// File: execute/aluShifter.sv
`timescale 1ns/100ps
`include "armCore_macros.svh"

module aluShifter (
  decodeBus.execute              bus,
  input  logic [`DATA_WIDTH-1:0] operandA,
  input  logic [`DATA_WIDTH-1:0] operandB,
  input  logic [`DATA_WIDTH-1:0] operandS,
  input  armCorePkg::flagSet     flagsIn,
  output logic [`DATA_WIDTH-1:0] result,
  output armCorePkg::flagSet     flagsNext
);

  logic [`DATA_WIDTH-1:0]   shifted;
  logic                     shiftCarry;
  logic [2*`DATA_WIDTH-1:0] rorWide;
  logic [`DATA_WIDTH-1:0]   operand2;
  logic                     op2Carry;
  logic [`DATA_WIDTH-1:0]   addX;
  logic [`DATA_WIDTH-1:0]   addY;
  logic                     addCin;
  logic [`DATA_WIDTH:0]     sum;
  logic                     overflow;
  logic                     isArith;
  logic [`DATA_WIDTH-1:0]   aluResult;
  logic [`DATA_WIDTH-1:0]   mulResult;

  assign rorWide = {operandB, operandB} >> bus.shiftAmount;

  // Barrel shifter, amount zero passes through with carry kept
  always_comb begin
    shifted    = operandB;
    shiftCarry = flagsIn.c;
    if (bus.shiftAmount != '0) begin
      case (bus.shiftKind)
        armCorePkg::shiftLsl: {shiftCarry, shifted} = {1'b0, operandB} << bus.shiftAmount;
        armCorePkg::shiftLsr: {shifted, shiftCarry} = {operandB, 1'b0} >> bus.shiftAmount;
        armCorePkg::shiftAsr: begin
          {shifted, shiftCarry} = $signed({operandB, 1'b0}) >>> bus.shiftAmount;
        end
        default: begin
          shifted    = rorWide[`DATA_WIDTH-1:0];
          shiftCarry = rorWide[`DATA_WIDTH-1];
        end
      endcase
    end
  end

  assign operand2 = bus.useImm ? bus.immValue : shifted;
  assign op2Carry = bus.useImm ? bus.immCarry : shiftCarry;

  // Subtraction as A + ~B + 1, RSB swaps the sides
  always_comb begin
    addX   = operandA;
    addY   = ~operand2;
    addCin = 1'b1;
    case (bus.op)
      armCorePkg::opRsb: begin
        addX = operand2;
        addY = ~operandA;
      end
      armCorePkg::opAdd: begin
        addY   = operand2;
        addCin = 1'b0;
      end
      default: ;
    endcase
  end

  assign sum      = {1'b0, addX} + {1'b0, addY} + addCin;
  assign overflow = (addX[`DATA_WIDTH-1] == addY[`DATA_WIDTH-1]) &&
                    (sum[`DATA_WIDTH-1] != addX[`DATA_WIDTH-1]);
  assign isArith  = (bus.op == armCorePkg::opSub) || (bus.op == armCorePkg::opRsb) ||
                    (bus.op == armCorePkg::opAdd) || (bus.op == armCorePkg::opCmp);

  always_comb begin
    case (bus.op)
      armCorePkg::opAnd: aluResult = operandA & operand2;
      armCorePkg::opEor: aluResult = operandA ^ operand2;
      armCorePkg::opOrr: aluResult = operandA | operand2;
      armCorePkg::opMvn: aluResult = ~operand2;
      armCorePkg::opSub,
      armCorePkg::opRsb,
      armCorePkg::opAdd,
      armCorePkg::opCmp: aluResult = sum[`DATA_WIDTH-1:0];
      default:           aluResult = operand2;
    endcase
  end

  // Low word only
  assign mulResult = operandB * operandS + (bus.accumulate ? operandA : '0);

  assign result = bus.isMult ? mulResult : aluResult;

  always_comb begin
    flagsNext.n = result[`DATA_WIDTH-1];
    flagsNext.z = (result == '0);
    if (bus.isMult) begin
      flagsNext.c = flagsIn.c;
      flagsNext.v = flagsIn.v;
    end else begin
      flagsNext.c = isArith ? sum[`DATA_WIDTH] : op2Carry;
      flagsNext.v = isArith ? overflow : flagsIn.v;
    end
  end

endmodule

// File: source/resultStage.sv
`timescale 1ns/100ps
`include "armCore_macros.svh"

module resultStage (
  input  logic                       clk,
  input  logic                       reset,
  decodeBus.result                   bus,
  input  logic [`DATA_WIDTH-1:0]     result,
  input  armCorePkg::flagSet         flagsNext,
  output armCorePkg::flagSet         flags,
  output logic                       writeEnable,
  output logic [`REG_ADDR_WIDTH-1:0] writeAddr,
  output logic [`DATA_WIDTH-1:0]     writeData,
  output logic                       outReq,
  input  logic                       outAck,
  output logic [`DATA_WIDTH-1:0]     resultValue,
  output logic [`REG_ADDR_WIDTH-1:0] resultReg,
  output logic                       resultWritten
);

  logic slotBusy;
  logic slotFree;

  // Slot frees once the consumer has dropped its ack
  assign slotFree = !slotBusy || (!outReq && !outAck);
  assign bus.take = bus.valid && slotFree;

  // Register file written on the capture edge
  assign writeEnable = bus.take && bus.writesDest;
  assign writeAddr   = bus.destReg;
  assign writeData   = result;

  always_ff @(posedge clk) begin
    if (reset) begin
      slotBusy <= 1'b0;
      outReq   <= 1'b0;
      flags    <= '0;
    end else begin
      if (bus.take) begin
        slotBusy <= 1'b1;
        outReq   <= 1'b1;
      end else begin
        if (outReq && outAck) begin
          outReq <= 1'b0;
        end
        if (slotBusy && !outReq && !outAck) begin
          slotBusy <= 1'b0;
        end
      end
      if (bus.take && bus.setFlags) begin
        flags <= flagsNext;
      end
    end
  end

  // Held stable for the consumer while outReq is up
  always_ff @(posedge clk) begin
    if (bus.take) begin
      resultValue   <= result;
      resultReg     <= bus.destReg;
      resultWritten <= bus.writesDest;
    end
  end

endmodule

// File: source/armDatapath.sv
`timescale 1ns/100ps
`include "armCore_macros.svh"

module armDatapath (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       inReq,
  output logic                       inAck,
  input  logic [`DATA_WIDTH-1:0]     instruction,
  output logic                       outReq,
  input  logic                       outAck,
  output logic [`DATA_WIDTH-1:0]     resultValue,
  output logic [`REG_ADDR_WIDTH-1:0] resultReg,
  output logic                       resultWritten,
  output logic [3:0]                 flags
);

  logic [`DATA_WIDTH-1:0]     readDataA;
  logic [`DATA_WIDTH-1:0]     readDataB;
  logic [`DATA_WIDTH-1:0]     readDataS;
  logic [`DATA_WIDTH-1:0]     execResult;
  armCorePkg::flagSet         flagsNext;
  armCorePkg::flagSet         flagState;
  logic                       writeEnable;
  logic [`REG_ADDR_WIDTH-1:0] writeAddr;
  logic [`DATA_WIDTH-1:0]     writeData;

  decodeBus bus ();

  instrDecoder decoder (
    .clk         (clk),
    .reset       (reset),
    .inReq       (inReq),
    .inAck       (inAck),
    .instruction (instruction),
    .carryFlag   (flagState.c),
    .take        (bus.take),
    .bus         (bus.decoder)
  );

  regFile rf (
    .clk         (clk),
    .reset       (reset),
    .readAddrA   (bus.srcA),
    .readAddrB   (bus.srcB),
    .readAddrS   (bus.srcS),
    .readDataA   (readDataA),
    .readDataB   (readDataB),
    .readDataS   (readDataS),
    .writeEnable (writeEnable),
    .writeAddr   (writeAddr),
    .writeData   (writeData)
  );

  aluShifter execute (
    .bus       (bus.execute),
    .operandA  (readDataA),
    .operandB  (readDataB),
    .operandS  (readDataS),
    .flagsIn   (flagState),
    .result    (execResult),
    .flagsNext (flagsNext)
  );

  resultStage writeback (
    .clk           (clk),
    .reset         (reset),
    .bus           (bus.result),
    .result        (execResult),
    .flagsNext     (flagsNext),
    .flags         (flagState),
    .writeEnable   (writeEnable),
    .writeAddr     (writeAddr),
    .writeData     (writeData),
    .outReq        (outReq),
    .outAck        (outAck),
    .resultValue   (resultValue),
    .resultReg     (resultReg),
    .resultWritten (resultWritten)
  );

  // NZCV from the flag register
  assign flags = flagState;

endmodule

// File: dv/clockGen.sv
`timescale 1ns/100ps

module clockGen #(
  parameter int periodNs    = 20,
  parameter int resetCycles = 10
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever begin
      #(periodNs / 2) clk = ~clk;
    end
  end

  // Released on a rising edge, like any synchronous input
  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// File: dv/armDatapath_tb.sv
`timescale 1ns/100ps

module armDatapath_tb;

  localparam int maxAckDelay    = 15;
  localparam int worstHandshake = maxAckDelay + 5;
  localparam int totalInstrs    = 32 + 300 + 200 + 40 + 60;
  localparam int cycleLimit     = 4 * totalInstrs * worstHandshake + 10;
  // Legal opcodes AND EOR SUB RSB ADD ORR MOV MVN CMP from the lowest nibble up
  localparam logic [35:0] legalOps = {4'd10, 4'd15, 4'd13, 4'd12, 4'd4, 4'd3, 4'd2, 4'd1, 4'd0};

  logic        clk;
  logic        reset;
  logic        inReq;
  logic        inAck;
  logic [31:0] instruction;
  logic        outReq;
  logic        outAck;
  logic [31:0] resultValue;
  logic [3:0]  resultReg;
  logic        resultWritten;
  logic [3:0]  flags;

  logic [31:0] modelRegs [16];
  logic [3:0]  modelFlags;
  // Expected outputs packed as flags, written, reg, value
  logic [40:0] expected [$];
  logic [31:0] stimQueue [$];
  logic [31:0] instrSeed;
  logic [31:0] delaySeed;
  int          errorCount = 0;
  int          checkCount = 0;
  int          testsFailed = 0;
  int          sentCount = 0;
  int          deliveredCount = 0;
  int          acceptedCount = 0;
  int          completedCount = 0;
  int          cycleCount = 0;
  logic        inAckLast = 1'b0;
  logic        outAckLast = 1'b0;
  logic        outReqLast = 1'b0;

  clockGen #(.periodNs(20), .resetCycles(10)) clocks (.clk(clk), .reset(reset));

  armDatapath uut (
    .clk           (clk),
    .reset         (reset),
    .inReq         (inReq),
    .inAck         (inAck),
    .instruction   (instruction),
    .outReq        (outReq),
    .outAck        (outAck),
    .resultValue   (resultValue),
    .resultReg     (resultReg),
    .resultWritten (resultWritten),
    .flags         (flags)
  );

  function automatic logic [31:0] lcgStep(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Upper half only since the low LCG bits repeat quickly
  function automatic logic [15:0] drawStimulus();
    instrSeed = lcgStep(instrSeed);
    return instrSeed[31:16];
  endfunction

  function automatic int drawDelay(input int maxDelay);
    delaySeed = lcgStep(delaySeed);
    return delaySeed[31:16] % (maxDelay + 1);
  endfunction

  function automatic logic [31:0] rotateRight(input logic [31:0] value, input int amount);
    return (value >> amount) | (value << (32 - amount));
  endfunction

  function automatic logic [31:0] dataProcWord(input logic [3:0] opc, input logic s,
      input logic [3:0] rn, input logic [3:0] rd, input logic imm, input logic [11:0] op2);
    return {4'he, 2'b00, imm, opc, s, rn, rd, op2};
  endfunction

  function automatic logic [31:0] multWord(input logic acc, input logic s, input logic [3:0] rd,
      input logic [3:0] rn, input logic [3:0] rs, input logic [3:0] rm);
    return {4'he, 6'd0, acc, s, rd, rn, rs, 4'b1001, rm};
  endfunction

  function automatic logic [31:0] randomDataProc();
    logic [15:0] r1;
    logic [15:0] r2;
    logic [11:0] op2;
    int          pick;
    r1 = drawStimulus();
    r2 = drawStimulus();
    pick = r1[15:12] % 9;
    // Register form keeps bit 4 clear for an immediate shift amount
    if (r1[0]) begin
      op2 = r2[11:0];
    end else begin
      op2 = {r2[11:5], 1'b0, r2[3:0]};
    end
    return dataProcWord(legalOps[pick*4 +: 4], r1[1], r1[11:8], r1[7:4], r1[0], op2);
  endfunction

  function automatic logic [31:0] randomMult();
    logic [15:0] r1;
    logic [15:0] r2;
    r1 = drawStimulus();
    r2 = drawStimulus();
    return multWord(r1[15], r1[14], r1[3:0], r1[7:4], r1[11:8], r2[3:0]);
  endfunction

  // Reference model of one instruction in program order
  task automatic applyModel(input logic [31:0] word);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] op2;
    logic [31:0] res;
    logic [32:0] wide;
    logic        shiftC;
    logic        newC;
    logic        newV;
    logic [3:0]  rd;
    logic        writes;
    int          amount;
    newC   = modelFlags[1];
    newV   = modelFlags[0];
    writes = 1'b1;
    if (word[27:22] == 6'd0 && word[7:4] == 4'b1001) begin
      rd  = word[19:16];
      res = modelRegs[word[3:0]] * modelRegs[word[11:8]];
      if (word[21]) begin
        res = res + modelRegs[word[15:12]];
      end
    end else begin
      rd     = word[15:12];
      a      = modelRegs[word[19:16]];
      b      = modelRegs[word[3:0]];
      op2    = b;
      shiftC = modelFlags[1];
      if (word[25]) begin
        amount = 2 * word[11:8];
        op2    = rotateRight({24'd0, word[7:0]}, amount);
        if (amount != 0) begin
          shiftC = op2[31];
        end
      end else begin
        amount = word[11:7];
        if (amount != 0) begin
          case (word[6:5])
            2'd0: begin
              op2    = b << amount;
              shiftC = b[32 - amount];
            end
            2'd1: begin
              op2    = b >> amount;
              shiftC = b[amount - 1];
            end
            2'd2: begin
              op2    = $signed(b) >>> amount;
              shiftC = b[amount - 1];
            end
            default: begin
              op2    = rotateRight(b, amount);
              shiftC = op2[31];
            end
          endcase
        end
      end
      newC = shiftC;
      case (word[24:21])
        4'd0:  res = a & op2;
        4'd1:  res = a ^ op2;
        4'd12: res = a | op2;
        4'd15: res = ~op2;
        4'd2, 4'd10: begin
          res  = a - op2;
          newC = (a >= op2);
          newV = (a[31] != op2[31]) && (res[31] != a[31]);
        end
        4'd3: begin
          res  = op2 - a;
          newC = (op2 >= a);
          newV = (op2[31] != a[31]) && (res[31] != op2[31]);
        end
        4'd4: begin
          wide = {1'b0, a} + {1'b0, op2};
          res  = wide[31:0];
          newC = wide[32];
          newV = (a[31] == op2[31]) && (res[31] != a[31]);
        end
        default: res = op2;
      endcase
      writes = (word[24:21] != 4'd10);
    end
    if (word[20]) begin
      modelFlags = {res[31], (res == 32'd0), newC, newV};
    end
    if (writes) begin
      modelRegs[rd] = res;
    end
    expected.push_back({modelFlags, writes, rd, res});
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
      input logic [31:0] wanted);
    checkCount++;
    if (actual !== wanted) begin
      $display("** Error: %s is 0x%h, expected 0x%h", name, actual, wanted);
      errorCount++;
    end
  endtask

  task automatic sendInstr(input logic [31:0] word, input int gap);
    applyModel(word);
    sentCount++;
    repeat (gap) @(posedge clk);
    instruction <= word;
    inReq       <= 1'b1;
    do begin
      @(posedge clk);
    end while (!inAck);
    inReq <= 1'b0;
    do begin
      @(posedge clk);
    end while (inAck);
  endtask

  task automatic receiveResults(input int count, input int maxDelay);
    logic [40:0] exp;
    repeat (count) begin
      do begin
        @(posedge clk);
      end while (!outReq);
      if (expected.size() == 0) begin
        $display("A result was delivered with no instruction outstanding");
        errorCount++;
      end else begin
        exp = expected.pop_front();
        checkValue("resultValue", resultValue, exp[31:0]);
        checkValue("resultReg", resultReg, exp[35:32]);
        checkValue("resultWritten", resultWritten, exp[36]);
        checkValue("flags", flags, exp[40:37]);
      end
      repeat (drawDelay(maxDelay)) @(posedge clk);
      outAck <= 1'b1;
      do begin
        @(posedge clk);
      end while (outReq);
      outAck <= 1'b0;
    end
  endtask

  // Producer and consumer run side by side over the queued words
  task automatic runBatch(input int maxGap, input int maxDelay);
    int count;
    count = stimQueue.size();
    fork
      begin
        while (stimQueue.size() > 0) begin
          sendInstr(stimQueue.pop_front(), drawStimulus() % (maxGap + 1));
        end
      end
      receiveResults(count, maxDelay);
    join
  endtask

  task automatic finishTest(input int number, input string title, input int errorsBefore);
    if (errorCount == errorsBefore) begin
      $display("Test %0d, %s: passed", number, title);
    end else begin
      $display("Test %0d, %s: failed with %0d errors", number, title,
               errorCount - errorsBefore);
      testsFailed++;
    end
  endtask

  // Accepted but unacknowledged items fit in decode plus the result register
  // Deliveries are counted from each rise of outReq
  always @(posedge clk) begin
    if (reset !== 1'b0) begin
      inAckLast  = 1'b0;
      outAckLast = 1'b0;
      outReqLast = 1'b0;
    end else begin
      if (!outAck && outAckLast) begin
        completedCount++;
      end
      if (outReq && !outReqLast) begin
        deliveredCount++;
      end
      if (inAck && !inAckLast) begin
        acceptedCount++;
        if (acceptedCount - completedCount > 2) begin
          $display("inAck rose with %0d instructions already in flight",
                   acceptedCount - completedCount - 1);
          errorCount++;
        end
      end
      inAckLast  = inAck;
      outAckLast = outAck;
      outReqLast = outReq;
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    int          errorsBefore;
    logic [3:0]  prevRd;
    logic [31:0] word;
    logic [15:0] pick;
    inReq       = 1'b0;
    outAck      = 1'b0;
    instruction = '0;
    instrSeed   = 32'h4228_2b1e;
    delaySeed   = ~32'h4228_2b1e;
    modelFlags  = '0;
    for (int i = 0; i < 16; i++) begin
      modelRegs[i] = '0;
    end
    while (reset !== 1'b0) begin
      @(posedge clk);
    end

    // Rotated immediate MOVs read back by ADD #0
    errorsBefore = errorCount;
    for (int r = 0; r < 16; r++) begin
      pick = drawStimulus();
      stimQueue.push_back(dataProcWord(4'd13, 1'b0, 4'd0, r[3:0], 1'b1, pick[11:0]));
    end
    for (int r = 0; r < 16; r++) begin
      stimQueue.push_back(dataProcWord(4'd4, 1'b0, r[3:0], r[3:0], 1'b1, 12'h000));
    end
    runBatch(2, 2);
    finishTest(1, "register write and read back", errorsBefore);

    errorsBefore = errorCount;
    for (int n = 0; n < 300; n++) begin
      stimQueue.push_back(randomDataProc());
    end
    runBatch(3, 3);
    finishTest(2, "random data processing", errorsBefore);

    errorsBefore = errorCount;
    for (int n = 0; n < 100; n++) begin
      stimQueue.push_back(randomMult());
      stimQueue.push_back(randomDataProc());
    end
    runBatch(3, 3);
    finishTest(3, "multiply mixed with data processing", errorsBefore);

    // Each source is the previous destination and CMP becomes ADD
    errorsBefore = errorCount;
    prevRd = 4'd0;
    for (int n = 0; n < 40; n++) begin
      word = randomDataProc();
      word[19:16] = prevRd;
      word[3:0]   = prevRd;
      if (word[24:21] == 4'd10) begin
        word[24:21] = 4'd4;
      end
      prevRd = word[15:12];
      stimQueue.push_back(word);
    end
    runBatch(0, 0);
    finishTest(4, "back-to-back dependent instructions", errorsBefore);

    errorsBefore = errorCount;
    for (int n = 0; n < 60; n++) begin
      pick = drawStimulus();
      if (pick[15]) begin
        stimQueue.push_back(randomMult());
      end else begin
        stimQueue.push_back(randomDataProc());
      end
    end
    runBatch(2, maxAckDelay);
    repeat (20) @(posedge clk);
    if (outReq !== 1'b0) begin
      $display("outReq is high with no instruction outstanding");
      errorCount++;
    end
    if (deliveredCount != sentCount || expected.size() != 0) begin
      $display("Delivered %0d results for %0d instructions sent", deliveredCount, sentCount);
      errorCount++;
    end
    finishTest(5, "slow consumer ordering and back-pressure", errorsBefore);

    $display("Tests run: 5, failed: %0d, checks: %0d, errors: %0d",
             testsFailed, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+common
common/armCorePkg.sv
common/decodeBus.sv
decode/instrDecoder.sv
source/regFile.sv
execute/aluShifter.sv
source/resultStage.sv
source/armDatapath.sv
dv/clockGen.sv
dv/armDatapath_tb.sv

// File: Bender.yml
package:
  name: arm_datapath

export_include_dirs:
  - common

sources:
  - common/armCorePkg.sv
  - common/decodeBus.sv
  - decode/instrDecoder.sv
  - source/regFile.sv
  - execute/aluShifter.sv
  - source/resultStage.sv
  - source/armDatapath.sv
  - target: test
    files:
      - dv/clockGen.sv
      - dv/armDatapath_tb.sv
